//--- rtl/ex_pkg.sv
package ex_pkg;

	// datapath and register index widths
	localparam int xlen       = 64;
	localparam int reg_addr_w = 5;

	// major opcodes handled by the execute stage
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op        = 7'b0110011;
	localparam logic [6:0] op_imm_32 = 7'b0011011;
	localparam logic [6:0] op_32     = 7'b0111011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_system = 7'b1110011;

	// integer alu funct3
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_sr      = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// 32-bit word forms
	localparam logic [2:0] f3_addw = 3'b000;
	localparam logic [2:0] f3_sllw = 3'b001;
	localparam logic [2:0] f3_srw  = 3'b101;

	// branch conditions
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// csr read-modify-write, bit 2 selects the immediate source
	localparam logic [2:0] f3_csrrw  = 3'b001;
	localparam logic [2:0] f3_csrrs  = 3'b010;
	localparam logic [2:0] f3_csrrc  = 3'b011;
	localparam logic [2:0] f3_csrrwi = 3'b101;
	localparam logic [2:0] f3_csrrsi = 3'b110;
	localparam logic [2:0] f3_csrrci = 3'b111;

	// m extension groups, word forms share the same codes
	localparam logic [2:0] f3_mul    = 3'b000;
	localparam logic [2:0] f3_mulh   = 3'b001;
	localparam logic [2:0] f3_mulhsu = 3'b010;
	localparam logic [2:0] f3_mulhu  = 3'b011;
	localparam logic [2:0] f3_div    = 3'b100;
	localparam logic [2:0] f3_divu   = 3'b101;
	localparam logic [2:0] f3_rem    = 3'b110;
	localparam logic [2:0] f3_remu   = 3'b111;

	localparam logic [6:0] funct7_base   = 7'b0000000;
	localparam logic [6:0] funct7_alt    = 7'b0100000;
	localparam logic [6:0] funct7_muldiv = 7'b0000001;

	typedef struct packed {
		logic [31:0]           inst;
		logic [xlen-1:0]       op1;
		logic [xlen-1:0]       op2;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       base;
		logic [xlen-1:0]       offset;
	} ex_issue_t;

	typedef struct packed {
		logic                  we;
		logic [reg_addr_w-1:0] addr;
		logic [xlen-1:0]       data;
	} wb_req_t;

	typedef struct packed {
		logic            en;
		logic [xlen-1:0] addr;
	} redirect_t;

	// op field is {opcode, funct3}
	typedef struct packed {
		logic            ready;
		logic [xlen-1:0] op1;
		logic [xlen-1:0] op2;
		logic [9:0]      op;
	} long_req_t;

	typedef struct packed {
		logic            busy;
		logic            finish;
		logic [xlen-1:0] data;
	} long_rsp_t;

endpackage

//--- rtl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
	input  ex_pkg::ex_issue_t issue_i,
	output ex_pkg::wb_req_t   wb_o
);

	import ex_pkg::*;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	// inst[30] picks sub and arithmetic shift
	logic            alt;
	logic [5:0]      shamt;
	logic [4:0]      shamt_w;
	logic [xlen-1:0] sum;
	logic [xlen-1:0] diff;
	logic            lt_s;
	logic            lt_u;
	logic [xlen-1:0] sll_res;
	logic [xlen-1:0] srl_res;
	logic [xlen-1:0] sra_res;
	logic [31:0]     sllw_res;
	logic [31:0]     srlw_res;
	logic [31:0]     sraw_res;
	logic            valid;
	logic [xlen-1:0] data;

	function automatic logic [xlen-1:0] sext32(input logic [31:0] val);
		return {{(xlen-32){val[31]}}, val};
	endfunction

	assign opcode  = issue_i.inst[6:0];
	assign funct3  = issue_i.inst[14:12];
	assign funct7  = issue_i.inst[31:25];
	assign alt     = issue_i.inst[30];
	// shift amount comes in op2, immediate or register alike
	assign shamt   = issue_i.op2[5:0];
	assign shamt_w = issue_i.op2[4:0];

	assign sum  = issue_i.op1 + issue_i.op2;
	assign diff = issue_i.op1 - issue_i.op2;
	assign lt_s = $signed(issue_i.op1) < $signed(issue_i.op2);
	assign lt_u = issue_i.op1 < issue_i.op2;

	// full width shifts, sra fills from bit 63
	assign sll_res = issue_i.op1 << shamt;
	assign srl_res = issue_i.op1 >> shamt;
	assign sra_res = $signed(issue_i.op1) >>> shamt;

	// word shifts only see the low half, sraw fills from bit 31
	assign sllw_res = issue_i.op1[31:0] << shamt_w;
	assign srlw_res = issue_i.op1[31:0] >> shamt_w;
	assign sraw_res = $signed(issue_i.op1[31:0]) >>> shamt_w;

	always_comb begin
		valid = 1'b0;
		data  = '0;
		case (opcode)
			op_imm, op: begin
				// register form needs base or alt funct7, muldiv goes elsewhere
				valid = (opcode == op_imm) || (funct7 == funct7_base) ||
					(funct7 == funct7_alt);
				case (funct3)
					f3_add_sub: data = (opcode == op && alt) ? diff : sum;
					f3_sll:     data = sll_res;
					f3_slt:     data = {{(xlen-1){1'b0}}, lt_s};
					f3_sltu:    data = {{(xlen-1){1'b0}}, lt_u};
					f3_xor:     data = issue_i.op1 ^ issue_i.op2;
					f3_sr:      data = alt ? sra_res : srl_res;
					f3_or:      data = issue_i.op1 | issue_i.op2;
					f3_and:     data = issue_i.op1 & issue_i.op2;
					default:    data = '0;
				endcase
			end
			op_imm_32, op_32: begin
				valid = (opcode == op_imm_32) || (funct7 == funct7_base) ||
					(funct7 == funct7_alt);
				case (funct3)
					f3_addw: data = sext32((opcode == op_32 && alt) ? diff[31:0] : sum[31:0]);
					f3_sllw: data = sext32(sllw_res);
					f3_srw:  data = sext32(alt ? sraw_res : srlw_res);
					default: valid = 1'b0;
				endcase
			end
			op_lui: begin
				// upper immediate already formed in op1
				valid = 1'b1;
				data  = issue_i.op1;
			end
			op_auipc, op_jal, op_jalr: begin
				// pc plus imm, or pc plus 4 as link
				valid = 1'b1;
				data  = sum;
			end
			default: begin
				valid = 1'b0;
			end
		endcase
	end

	// zero when idle so the commit merge can or the sources
	assign wb_o.we   = valid;
	assign wb_o.addr = valid ? issue_i.rd : '0;
	assign wb_o.data = valid ? data : '0;

endmodule

//--- rtl/ex_branch.sv
`timescale 1ns/1ps

module ex_branch (
	input  ex_pkg::ex_issue_t issue_i,
	output ex_pkg::redirect_t redirect_o
);

	import ex_pkg::*;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            eq;
	logic            lt_s;
	logic            lt_u;
	logic            taken;
	logic [xlen-1:0] target;

	assign opcode = issue_i.inst[6:0];
	assign funct3 = issue_i.inst[14:12];

	assign eq     = issue_i.op1 == issue_i.op2;
	assign lt_s   = $signed(issue_i.op1) < $signed(issue_i.op2);
	assign lt_u   = issue_i.op1 < issue_i.op2;
	// pc+imm for branch and jal, rs1+imm for jalr, formed upstream
	assign target = issue_i.base + issue_i.offset;

	always_comb begin
		taken = 1'b0;
		case (opcode)
			op_branch: begin
				case (funct3)
					f3_beq:  taken = eq;
					f3_bne:  taken = ~eq;
					f3_blt:  taken = lt_s;
					f3_bge:  taken = ~lt_s;
					f3_bltu: taken = lt_u;
					f3_bgeu: taken = ~lt_u;
					default: taken = 1'b0;
				endcase
			end
			// jumps are unconditional
			op_jal, op_jalr: taken = 1'b1;
			default:         taken = 1'b0;
		endcase
	end

	assign redirect_o.en   = taken;
	assign redirect_o.addr = taken ? target : '0;

endmodule

//--- rtl/ex_csr_op.sv
`timescale 1ns/1ps

module ex_csr_op (
	input  ex_pkg::ex_issue_t         issue_i,
	input  logic [ex_pkg::xlen-1:0]   csr_rdata_i,
	output logic [ex_pkg::xlen-1:0]   csr_wdata_o,
	output ex_pkg::wb_req_t           wb_o
);

	import ex_pkg::*;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [xlen-1:0] uimm;
	logic [xlen-1:0] src;
	logic            hit;
	logic [xlen-1:0] new_val;

	assign opcode = issue_i.inst[6:0];
	assign funct3 = issue_i.inst[14:12];
	// rs1 field taken as a 5-bit zero-extended immediate
	assign uimm   = {{(xlen-5){1'b0}}, issue_i.inst[19:15]};
	assign src    = funct3[2] ? uimm : issue_i.op1;

	always_comb begin
		hit     = 1'b0;
		new_val = '0;
		if (opcode == op_system) begin
			hit = 1'b1;
			case (funct3)
				f3_csrrw, f3_csrrwi: new_val = src;
				f3_csrrs, f3_csrrsi: new_val = csr_rdata_i | src;
				f3_csrrc, f3_csrrci: new_val = csr_rdata_i & ~src;
				// ecall, ebreak, mret and friends are not csr accesses
				default:             hit = 1'b0;
			endcase
		end
	end

	assign csr_wdata_o = new_val;
	// old csr value lands in rd
	assign wb_o.we     = hit;
	assign wb_o.addr   = hit ? issue_i.rd : '0;
	assign wb_o.data   = hit ? csr_rdata_i : '0;

endmodule

//--- rtl/ex_long_op.sv
`timescale 1ns/1ps

module ex_long_op #(
	// 0 claims the multiply group, 1 the divide group
	parameter bit is_div = 1'b0
) (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  ex_pkg::ex_issue_t   issue_i,
	input  ex_pkg::long_rsp_t   rsp_i,
	output ex_pkg::long_req_t   req_o,
	output ex_pkg::wb_req_t     wb_o,
	output ex_pkg::redirect_t   redirect_o,
	output logic                hold_o
);

	import ex_pkg::*;

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic                  is_m_op;
	logic                  mul_grp;
	logic                  div_grp;
	logic                  claim;
	logic [reg_addr_w-1:0] rd_q;

	assign opcode  = issue_i.inst[6:0];
	assign funct3  = issue_i.inst[14:12];
	assign funct7  = issue_i.inst[31:25];
	assign is_m_op = (funct7 == funct7_muldiv) && (opcode == op || opcode == op_32);

	always_comb begin
		mul_grp = 1'b0;
		div_grp = 1'b0;
		case (funct3)
			f3_mul:                       mul_grp = 1'b1;
			// high-half products have no word form
			f3_mulh, f3_mulhsu, f3_mulhu: mul_grp = (opcode == op);
			f3_div, f3_divu, f3_rem, f3_remu: div_grp = 1'b1;
			default:                      mul_grp = 1'b0;
		endcase
	end

	assign claim = is_m_op && (is_div ? div_grp : mul_grp);

	// destination of the op in flight, kept until finish
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_q <= '0;
		end else if (claim) begin
			rd_q <= issue_i.rd;
		end
	end

	always_comb begin
		req_o.ready = 1'b0;
		req_o.op1   = issue_i.op1;
		req_o.op2   = issue_i.op2;
		req_o.op    = {opcode, funct3};
		wb_o        = '0;
		redirect_o  = '0;
		hold_o      = 1'b0;
		if (claim) begin
			// dispatch, refetch the same instruction while the unit works
			req_o.ready     = 1'b1;
			hold_o          = 1'b1;
			redirect_o.en   = 1'b1;
			redirect_o.addr = issue_i.base + issue_i.offset;
		end else if (rsp_i.finish) begin
			// finish beats busy
			wb_o.we   = 1'b1;
			wb_o.addr = rd_q;
			wb_o.data = rsp_i.data;
		end else if (rsp_i.busy) begin
			req_o.ready = 1'b1;
			hold_o      = 1'b1;
		end
	end

	// unit never sees a request in the cycle its result retires
	a_ready_wb_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(claim && rsp_i.finish))
		else $error("long op ready and write-back together");

endmodule

//--- rtl/ex_commit.sv
`timescale 1ns/1ps

module ex_commit (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  ex_pkg::wb_req_t          alu_wb_i,
	input  ex_pkg::wb_req_t          csr_wb_i,
	input  ex_pkg::wb_req_t          mul_wb_i,
	input  ex_pkg::wb_req_t          div_wb_i,
	input  ex_pkg::redirect_t        br_redirect_i,
	input  ex_pkg::redirect_t        mul_redirect_i,
	input  ex_pkg::redirect_t        div_redirect_i,
	input  logic                     mul_hold_i,
	input  logic                     div_hold_i,
	input  logic                     csr_we_i,
	input  logic                     int_assert_i,
	input  logic [ex_pkg::xlen-1:0]  int_addr_i,
	output ex_pkg::wb_req_t          rd_wb_o,
	output ex_pkg::redirect_t        redirect_o,
	output logic                     hold_o,
	output logic                     csr_we_o
);

	// sources drive zero when idle, so a plain or merges them
	assign rd_wb_o.we   = ~int_assert_i &
		(alu_wb_i.we | csr_wb_i.we | mul_wb_i.we | div_wb_i.we);
	assign rd_wb_o.addr = alu_wb_i.addr | csr_wb_i.addr | mul_wb_i.addr | div_wb_i.addr;
	assign rd_wb_o.data = alu_wb_i.data | csr_wb_i.data | mul_wb_i.data | div_wb_i.data;

	// interrupt takes the fetch path over any branch or refetch
	assign redirect_o.en   = int_assert_i |
		br_redirect_i.en | mul_redirect_i.en | div_redirect_i.en;
	assign redirect_o.addr = int_assert_i ? int_addr_i :
		(br_redirect_i.addr | mul_redirect_i.addr | div_redirect_i.addr);

	assign hold_o   = mul_hold_i | div_hold_i;
	// no csr update for an instruction being preempted
	assign csr_we_o = csr_we_i & ~int_assert_i;

	// decode keeps alu, csr and finishing units apart
	a_one_wb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0({alu_wb_i.we, csr_wb_i.we, mul_wb_i.we, div_wb_i.we}))
		else $error("more than one write-back source");

	a_one_redirect: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0({br_redirect_i.en, mul_redirect_i.en, div_redirect_i.en}))
		else $error("more than one redirect source");

endmodule

//--- rtl/ex_top.sv
`timescale 1ns/1ps

module ex_top (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  ex_pkg::ex_issue_t        issue_i,
	input  logic                     csr_we_i,
	input  logic [ex_pkg::xlen-1:0]  csr_rdata_i,
	input  logic                     int_assert_i,
	input  logic [ex_pkg::xlen-1:0]  int_addr_i,
	input  ex_pkg::long_rsp_t        mul_rsp_i,
	input  ex_pkg::long_rsp_t        div_rsp_i,
	output ex_pkg::wb_req_t          rd_wb_o,
	output ex_pkg::redirect_t        redirect_o,
	output logic                     hold_o,
	output logic                     csr_we_o,
	output logic [ex_pkg::xlen-1:0]  csr_wdata_o,
	output ex_pkg::long_req_t        mul_req_o,
	output ex_pkg::long_req_t        div_req_o
);

	import ex_pkg::*;

	wb_req_t   alu_wb;
	wb_req_t   csr_wb;
	wb_req_t   mul_wb;
	wb_req_t   div_wb;
	redirect_t br_redirect;
	redirect_t mul_redirect;
	redirect_t div_redirect;
	logic      mul_hold;
	logic      div_hold;

	// single-cycle paths
	ex_alu u_alu (
		.issue_i (issue_i),
		.wb_o    (alu_wb)
	);

	ex_branch u_branch (
		.issue_i    (issue_i),
		.redirect_o (br_redirect)
	);

	ex_csr_op u_csr (
		.issue_i     (issue_i),
		.csr_rdata_i (csr_rdata_i),
		.csr_wdata_o (csr_wdata_o),
		.wb_o        (csr_wb)
	);

	// external iterative units
	ex_long_op #(.is_div(1'b0)) u_mul (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.issue_i    (issue_i),
		.rsp_i      (mul_rsp_i),
		.req_o      (mul_req_o),
		.wb_o       (mul_wb),
		.redirect_o (mul_redirect),
		.hold_o     (mul_hold)
	);

	ex_long_op #(.is_div(1'b1)) u_div (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.issue_i    (issue_i),
		.rsp_i      (div_rsp_i),
		.req_o      (div_req_o),
		.wb_o       (div_wb),
		.redirect_o (div_redirect),
		.hold_o     (div_hold)
	);

	ex_commit u_commit (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.alu_wb_i       (alu_wb),
		.csr_wb_i       (csr_wb),
		.mul_wb_i       (mul_wb),
		.div_wb_i       (div_wb),
		.br_redirect_i  (br_redirect),
		.mul_redirect_i (mul_redirect),
		.div_redirect_i (div_redirect),
		.mul_hold_i     (mul_hold),
		.div_hold_i     (div_hold),
		.csr_we_i       (csr_we_i),
		.int_assert_i   (int_assert_i),
		.int_addr_i     (int_addr_i),
		.rd_wb_o        (rd_wb_o),
		.redirect_o     (redirect_o),
		.hold_o         (hold_o),
		.csr_we_o       (csr_we_o)
	);

endmodule

//--- verif/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top;

	import ex_pkg::*;

	// one vector is n_words hex words on one line of the data file
	localparam int n_vec       = 31;
	localparam int n_words     = 16;
	localparam int n_mem       = n_vec * n_words;
	// vectors plus reset plus slack
	localparam int cycle_limit = n_vec + 8 + 20;

	logic       clk_i;
	logic       arst_n_i;
	ex_issue_t  issue;
	logic       csr_we;
	logic [63:0] csr_rdata;
	logic       int_assert;
	logic [63:0] int_addr;
	long_rsp_t  mul_rsp;
	long_rsp_t  div_rsp;

	wb_req_t    rd_wb;
	redirect_t  redirect;
	logic       hold;
	logic       csr_we_out;
	logic [63:0] csr_wdata;
	long_req_t  mul_req;
	long_req_t  div_req;

	logic [63:0] vec_mem [0:n_mem-1];
	int          n_errors;
	int          n_checks;
	int          cycle_cnt;

	ex_top dut0 (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.issue_i      (issue),
		.csr_we_i     (csr_we),
		.csr_rdata_i  (csr_rdata),
		.int_assert_i (int_assert),
		.int_addr_i   (int_addr),
		.mul_rsp_i    (mul_rsp),
		.div_rsp_i    (div_rsp),
		.rd_wb_o      (rd_wb),
		.redirect_o   (redirect),
		.hold_o       (hold),
		.csr_we_o     (csr_we_out),
		.csr_wdata_o  (csr_wdata),
		.mul_req_o    (mul_req),
		.div_req_o    (div_req)
	);

	// 40 ns clock
	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// background for the vector memory, so a short file shows up
	function automatic logic [63:0] fill_word(input int idx);
		return {2{32'(idx) ^ 32'h5a5a_a5a5}};
	endfunction

	task automatic compare(input string name, input int v, input logic [63:0] exp,
		input logic [63:0] act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("MISMATCH %s vector %0d expected 0x%h actual 0x%h", name, v, exp, act);
		end
	endtask

	// words 0..10 are stimulus
	task automatic apply_vector(input int v);
		int b;
		b = v * n_words;
		issue.inst     = vec_mem[b][31:0];
		issue.op1      = vec_mem[b+1];
		issue.op2      = vec_mem[b+2];
		issue.rd       = vec_mem[b+3][4:0];
		issue.base     = vec_mem[b+4];
		issue.offset   = vec_mem[b+5];
		// control bits: csr_we, int, mul busy/finish, div busy/finish
		csr_we         = vec_mem[b+6][0];
		int_assert     = vec_mem[b+6][1];
		mul_rsp.busy   = vec_mem[b+6][2];
		mul_rsp.finish = vec_mem[b+6][3];
		div_rsp.busy   = vec_mem[b+6][4];
		div_rsp.finish = vec_mem[b+6][5];
		csr_rdata      = vec_mem[b+7];
		int_addr       = vec_mem[b+8];
		mul_rsp.data   = vec_mem[b+9];
		div_rsp.data   = vec_mem[b+10];
	endtask

	// words 11..15 are expected outputs
	task automatic check_vector(input int v);
		int          b;
		logic [63:0] exp_wb;
		logic [63:0] exp_flags;
		logic [63:0] exp_op;
		b         = v * n_words;
		exp_wb    = vec_mem[b+11];
		exp_flags = vec_mem[b+13];
		// request op field is opcode then funct3 of the issued word
		exp_op    = 64'({vec_mem[b][6:0], vec_mem[b][14:12]});
		compare("rd_wb_o.we", v, 64'(exp_wb[5]), 64'(rd_wb.we));
		// addr and data only mean something with we set
		if (exp_wb[5]) begin
			compare("rd_wb_o.addr", v, 64'(exp_wb[4:0]), 64'(rd_wb.addr));
			compare("rd_wb_o.data", v, vec_mem[b+12], rd_wb.data);
		end
		compare("redirect_o.en", v, 64'(exp_flags[0]), 64'(redirect.en));
		compare("hold_o", v, 64'(exp_flags[1]), 64'(hold));
		compare("csr_we_o", v, 64'(exp_flags[2]), 64'(csr_we_out));
		compare("mul_req_o.ready", v, 64'(exp_flags[3]), 64'(mul_req.ready));
		compare("div_req_o.ready", v, 64'(exp_flags[4]), 64'(div_req.ready));
		if (exp_flags[0]) begin
			compare("redirect_o.addr", v, vec_mem[b+14], redirect.addr);
		end
		compare("csr_wdata_o", v, vec_mem[b+15], csr_wdata);
		// payload of a dispatch, ready without the unit busy
		if (exp_flags[3] && !mul_rsp.busy) begin
			compare("mul_req_o.op1", v, vec_mem[b+1], mul_req.op1);
			compare("mul_req_o.op2", v, vec_mem[b+2], mul_req.op2);
			compare("mul_req_o.op", v, exp_op, 64'(mul_req.op));
		end
		if (exp_flags[4] && !div_rsp.busy) begin
			compare("div_req_o.op1", v, vec_mem[b+1], div_req.op1);
			compare("div_req_o.op2", v, vec_mem[b+2], div_req.op2);
			compare("div_req_o.op", v, exp_op, 64'(div_req.op));
		end
	endtask

	initial begin
		issue      = '0;
		csr_we     = 1'b0;
		csr_rdata  = '0;
		int_assert = 1'b0;
		int_addr   = '0;
		mul_rsp    = '0;
		div_rsp    = '0;
		arst_n_i   = 1'b0;
		n_errors   = 0;
		n_checks   = 0;

		for (int i = 0; i < n_mem; i++) begin
			vec_mem[i] = fill_word(i);
		end
		$readmemh("verif/ex_testdata.hex", vec_mem);
		// last word untouched means the file ran out early
		if (vec_mem[n_mem-1] == fill_word(n_mem - 1)) begin
			n_errors++;
			$display("test data file holds fewer than %0d vectors", n_vec);
		end

		// reset over 8 edges, released off the edge
		repeat (8) @(posedge clk_i);
		#2;
		arst_n_i = 1'b1;

		for (int v = 0; v < n_vec; v++) begin
			@(posedge clk_i);
			#2;
			apply_vector(v);
			// sample 2 ns before the next edge
			#36;
			check_vector(v);
		end

		$display("vectors=%0d checks=%0d errors=%0d", n_vec, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// watchdog on clock cycles
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk_i);
			cycle_cnt++;
		end
		$display("timeout, run did not end within %0d cycles", cycle_limit);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- verif/ex_testdata.hex
// inst op1 op2 rd base offset ctrl{df,db,mf,mb,int,csr_we} csr_rdata int_addr mul_data div_data
// then wb{we,addr[4:0]} wb_data flags{div_rdy,mul_rdy,csr_we,hold,redir} redir_addr csr_wdata
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
00000033 7fffffffffffffff 1 1 0 0 0 0 0 0 0 21 8000000000000000 0 0 0
40000033 5 7 2 0 0 0 0 0 0 0 22 fffffffffffffffe 0 0 0
00002033 ffffffffffffffff 1 3 0 0 0 0 0 0 0 23 1 0 0 0
00003013 ffffffffffffffff 1 4 0 0 0 0 0 0 0 24 0 0 0 0
00004013 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 5 0 0 0 0 0 0 0 25 0ff00ff00ff00ff0 0 0 0
00006013 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 6 0 0 0 0 0 0 0 26 0fff0fff0fff0fff 0 0 0
00001013 3 44 7 0 0 0 0 0 0 0 27 30 0 0 0
40005033 8000000000000000 4 8 0 0 0 0 0 0 0 28 f800000000000000 0 0 0
0000003b 7fffffff 1 9 0 0 0 0 0 0 0 29 ffffffff80000000 0 0 0
4000003b 100000000 1 a 0 0 0 0 0 0 0 2a ffffffffffffffff 0 0 0
4000501b 80000000 24 b 0 0 0 0 0 0 0 2b fffffffff8000000 0 0 0
0000503b ffffffff80000000 21 c 0 0 0 0 0 0 0 2c 40000000 0 0 0
12345037 12345000 0 d 0 0 0 0 0 0 0 2d 12345000 0 0 0
00001017 80000000 1000 e 0 0 0 0 0 0 0 2e 80001000 0 0 0
0000006f 80000100 4 1 80000100 40 0 0 0 0 0 21 80000104 1 80000140 0
00000067 80000200 4 1 90000000 ffffffffffffff00 0 0 0 0 0 21 80000204 1 8fffff00 0
00000063 1234 1234 0 80000300 10 0 0 0 0 0 0 0 1 80000310 0
00004063 5 ffffffffffffffff 0 80000300 20 0 0 0 0 0 0 0 0 0 0
00007063 ffffffffffffffff 5 0 80000400 fffffffffffffff8 0 0 0 0 0 0 0 1 800003f8 0
00001073 deadbeef 0 11 0 0 1 5555 0 0 0 31 5555 4 0 deadbeef
00002073 f0 0 12 0 0 1 f 0 0 0 32 f 4 0 ff
00057073 ffff 0 13 0 0 1 ff 0 0 0 33 ff 4 0 f5
00000033 1 2 14 0 0 2 0 80000800 0 0 0 0 1 80000800 0
00001073 1234 0 15 0 0 3 10 80000900 0 0 0 0 1 80000900 1234
02000033 6 7 16 80000500 0 0 0 0 0 0 0 0 b 80000500 0
00000033 1 1 17 0 0 4 0 0 0 0 37 2 a 0 0
0 0 0 0 0 0 c 0 0 2a bad 36 2a 0 0 0
0200503b 64 7 18 800005fc 4 0 0 0 0 0 0 0 13 80000600 0
0 0 0 0 0 0 10 0 0 0 0 0 0 12 0 0
0 0 0 0 0 0 30 0 0 1111 e 38 e 0 0 0

//--- all.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_branch.sv
rtl/ex_csr_op.sv
rtl/ex_long_op.sv
rtl/ex_commit.sv
rtl/ex_top.sv
verif/tb_ex_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_ex_top
FLIST     := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
